// ==== include/lc3b_config.svh ====
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// r0 to r7
`define LC3B_NUM_REGS 8

// data and address width
`define LC3B_WORD_W 16

`endif

// ==== logic/lc3b_pkg.sv ====
package lc3b_pkg;

`include "lc3b_config.svh"

typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
// n z p, msb first
typedef logic [2:0] lc3b_nzp;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_not  = 4'b1001,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	idle,
	fetch_grant,
	data_grant
} arb_state_t;

typedef struct packed {
	lc3b_opcode opcode;
	logic ld_reg;
	logic ld_cc;
	logic imm_sel;
	lc3b_word offset;
} lc3b_ctrl;

// on a br the dr field carries the nzp mask
typedef struct packed {
	logic valid;
	lc3b_word npc;
	lc3b_ctrl ctrl;
	lc3b_reg dr;
	lc3b_word src_a;
	lc3b_word src_b;
} de_ex_t;

typedef struct packed {
	logic valid;
	lc3b_word npc;
	lc3b_ctrl ctrl;
	lc3b_reg dr;
	lc3b_word result;
	lc3b_word addr;
} ex_mem_t;

typedef struct packed {
	logic valid;
	lc3b_word npc;
	lc3b_ctrl ctrl;
	lc3b_reg dr;
	lc3b_word result;
	lc3b_word addr;
	lc3b_word data;
} mem_wb_t;

typedef struct packed {
	logic cyc;
	logic stb;
	logic we;
	lc3b_word adr;
	lc3b_word dat;
	logic [1:0] sel;
} wb_req_t;

typedef struct packed {
	logic ack;
	lc3b_word dat;
} wb_rsp_t;

endpackage

// ==== logic/lc3b_regfile.sv ====
`timescale 1ns/1ns
`include "lc3b_config.svh"

module lc3b_regfile (
	input  logic clk,
	input  logic rst_n,
	input  lc3b_pkg::lc3b_reg rd_sr1,
	input  lc3b_pkg::lc3b_reg rd_sr2,
	output lc3b_pkg::lc3b_word sr1_data,
	output lc3b_pkg::lc3b_word sr2_data,
	input  logic ld_reg,
	input  logic ld_cc,
	input  lc3b_pkg::lc3b_reg wr_dr,
	input  lc3b_pkg::lc3b_word wr_data,
	output lc3b_pkg::lc3b_nzp cc
);
	import lc3b_pkg::*;

	lc3b_word regs [`LC3B_NUM_REGS];
	lc3b_nzp gen_cc;

	assign sr1_data = regs[rd_sr1];
	assign sr2_data = regs[rd_sr2];

	// sign and zero test of the value being written
	assign gen_cc = wr_data[$bits(lc3b_word)-1] ? 3'b100 :
		(wr_data == '0) ? 3'b010 : 3'b001;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			cc <= 3'b010;
		end else begin
			if (ld_reg)
				regs[wr_dr] <= wr_data;
			if (ld_cc)
				cc <= gen_cc;
		end
	end

endmodule

// ==== logic/fetch.sv ====
`timescale 1ns/1ns
`include "lc3b_config.svh"

module fetch (
	input  logic clk,
	input  logic rst_n,
	input  logic stall,
	input  logic br_hold,
	input  logic redirect,
	input  lc3b_pkg::lc3b_word target,
	input  logic halt,
	output lc3b_pkg::wb_req_t req,
	input  lc3b_pkg::wb_rsp_t rsp,
	output logic f_valid,
	output lc3b_pkg::lc3b_word f_npc,
	output lc3b_pkg::lc3b_word f_ir
);
	import lc3b_pkg::*;

	lc3b_word pc;
	lc3b_word buf_ir;
	logic req_on;
	logic buf_valid;
	logic stopped;
	logic got;

	assign got = req_on && rsp.ack;

	// word arriving while decode is held parks in buf_ir
	assign f_valid = buf_valid || got;
	assign f_ir = buf_valid ? buf_ir : rsp.dat;
	// pc has already stepped once the word is buffered
	assign f_npc = buf_valid ? pc : pc + 16'd2;

	always_comb begin
		req = '0;
		req.cyc = req_on;
		req.stb = req_on;
		req.adr = pc;
		req.sel = 2'b11;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `LC3B_RESET_PC;
			req_on <= 1'b0;
			buf_valid <= 1'b0;
			stopped <= 1'b0;
		end else begin
			if (halt)
				stopped <= 1'b1;
			if (redirect)
				pc <= target;
			else if (got)
				pc <= pc + 16'd2;
			// one word at a time, new request only once decode has seen the last one
			if (req_on)
				req_on <= !rsp.ack;
			else
				req_on <= !stopped && !halt && !br_hold && !buf_valid;
			if (!stall)
				buf_valid <= 1'b0;
			else if (got)
				buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (got)
			buf_ir <= rsp.dat;
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req.stb && !rsp.ack |=> $stable(req));

endmodule

// ==== logic/decode.sv ====
`timescale 1ns/1ns

module decode (
	input  logic f_valid,
	input  lc3b_pkg::lc3b_word f_ir,
	input  lc3b_pkg::lc3b_word f_npc,
	output lc3b_pkg::lc3b_reg rd_sr1,
	output lc3b_pkg::lc3b_reg rd_sr2,
	input  lc3b_pkg::lc3b_word sr1_data,
	input  lc3b_pkg::lc3b_word sr2_data,
	input  lc3b_pkg::lc3b_reg ex_dr,
	input  logic ex_ld_reg,
	input  lc3b_pkg::lc3b_reg mem_dr,
	input  logic mem_ld_reg,
	input  lc3b_pkg::lc3b_reg wb_dr,
	input  logic wb_ld_reg,
	input  logic cc_busy,
	output lc3b_pkg::de_ex_t de_out,
	output logic dep_stall,
	output logic br_hold,
	output logic trap_seen
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	lc3b_ctrl ctrl;
	logic use_sr1;
	logic use_sr2;
	logic use_cc;

	function automatic logic in_flight(lc3b_reg r);
		return (ex_ld_reg && ex_dr == r) || (mem_ld_reg && mem_dr == r) ||
			(wb_ld_reg && wb_dr == r);
	endfunction

	assign opcode = lc3b_opcode'(f_ir[15:12]);
	assign rd_sr1 = f_ir[8:6];
	// str reads its data register on the second port
	assign rd_sr2 = (opcode == op_str) ? f_ir[11:9] : f_ir[2:0];

	always_comb begin
		ctrl = '0;
		ctrl.opcode = opcode;
		use_sr1 = 1'b0;
		use_sr2 = 1'b0;
		use_cc = 1'b0;
		case (opcode)
			op_add, op_and: begin
				ctrl.ld_reg = 1'b1;
				ctrl.ld_cc = 1'b1;
				ctrl.imm_sel = f_ir[5];
				ctrl.offset = {{11{f_ir[4]}}, f_ir[4:0]};
				use_sr1 = 1'b1;
				use_sr2 = !f_ir[5];
			end
			op_not: begin
				ctrl.ld_reg = 1'b1;
				ctrl.ld_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			op_br: begin
				ctrl.offset = {{7{f_ir[8]}}, f_ir[8:0]};
				use_cc = 1'b1;
			end
			op_lea: begin
				// lc-3b lea leaves cc alone
				ctrl.ld_reg = 1'b1;
				ctrl.offset = {{7{f_ir[8]}}, f_ir[8:0]};
			end
			op_ldr: begin
				ctrl.ld_reg = 1'b1;
				ctrl.ld_cc = 1'b1;
				ctrl.offset = {{10{f_ir[5]}}, f_ir[5:0]};
				use_sr1 = 1'b1;
			end
			op_str: begin
				ctrl.offset = {{10{f_ir[5]}}, f_ir[5:0]};
				use_sr1 = 1'b1;
				use_sr2 = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// no forwarding, so wait out every older writer
	assign dep_stall = f_valid && ((use_sr1 && in_flight(rd_sr1)) ||
		(use_sr2 && in_flight(rd_sr2)) || (use_cc && cc_busy));

	always_comb begin
		de_out.valid = f_valid && !dep_stall;
		de_out.npc = f_npc;
		de_out.ctrl = ctrl;
		de_out.dr = f_ir[11:9];
		de_out.src_a = sr1_data;
		de_out.src_b = sr2_data;
	end

	assign br_hold = f_valid && opcode == op_br;
	assign trap_seen = f_valid && opcode == op_trap;

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/1ns

module execute (
	input  lc3b_pkg::de_ex_t de_in,
	input  lc3b_pkg::lc3b_nzp cc,
	output lc3b_pkg::ex_mem_t ex_out,
	output logic redirect,
	output lc3b_pkg::lc3b_word target
);
	import lc3b_pkg::*;

	lc3b_word opnd_b;
	lc3b_word off2;
	lc3b_word alu;

	// imm_sel only ever set on add and and
	assign opnd_b = de_in.ctrl.imm_sel ? de_in.ctrl.offset : de_in.src_b;
	// word offsets scaled to bytes
	assign off2 = {de_in.ctrl.offset[14:0], 1'b0};
	assign target = de_in.npc + off2;

	always_comb begin
		case (de_in.ctrl.opcode)
			op_add:
				alu = de_in.src_a + opnd_b;
			op_and:
				alu = de_in.src_a & opnd_b;
			op_not:
				alu = ~de_in.src_a;
			op_lea:
				alu = target;
			// store data rides in the result field
			op_str:
				alu = de_in.src_b;
			default:
				alu = '0;
		endcase
	end

	// dr holds the nzp mask for a branch
	assign redirect = de_in.valid && de_in.ctrl.opcode == op_br && |(de_in.dr & cc);

	always_comb begin
		ex_out.valid = de_in.valid;
		ex_out.npc = de_in.npc;
		ex_out.ctrl = de_in.ctrl;
		ex_out.dr = de_in.dr;
		ex_out.result = alu;
		ex_out.addr = de_in.src_a + off2;
	end

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
	input  logic clk,
	input  logic rst_n,
	input  lc3b_pkg::ex_mem_t ex_in,
	output lc3b_pkg::wb_req_t req,
	input  lc3b_pkg::wb_rsp_t rsp,
	output lc3b_pkg::mem_wb_t mem_out,
	output logic mem_busy
);
	import lc3b_pkg::*;

	logic is_ld;
	logic is_st;
	logic done;
	lc3b_word rdata;

	assign is_ld = ex_in.valid && ex_in.ctrl.opcode == op_ldr;
	assign is_st = ex_in.valid && ex_in.ctrl.opcode == op_str;
	assign mem_busy = (is_ld || is_st) && !done;

	always_comb begin
		req = '0;
		req.cyc = mem_busy;
		req.stb = mem_busy;
		req.we = mem_busy && is_st;
		req.adr = ex_in.addr;
		req.dat = ex_in.result;
		req.sel = 2'b11;
	end

	// set by the ack, cleared as the instruction moves on
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (!mem_busy)
			done <= 1'b0;
		else if (rsp.ack)
			done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rsp.ack)
			rdata <= rsp.dat;
	end

	always_comb begin
		mem_out.valid = ex_in.valid;
		mem_out.npc = ex_in.npc;
		mem_out.ctrl = ex_in.ctrl;
		mem_out.dr = ex_in.dr;
		mem_out.result = ex_in.result;
		mem_out.addr = ex_in.addr;
		mem_out.data = rdata;
	end

	// a load carries a register write from decode, a store does not
	a_no_ld_write: assert property (@(posedge clk) disable iff (!rst_n)
		req.stb && ex_in.ctrl.ld_reg |-> !req.we);
	a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.ack |=> !req.stb);

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  lc3b_pkg::wb_req_t f_req,
	output lc3b_pkg::wb_rsp_t f_rsp,
	input  lc3b_pkg::wb_req_t d_req,
	output lc3b_pkg::wb_rsp_t d_rsp,
	output lc3b_pkg::wb_req_t wb_req,
	input  lc3b_pkg::wb_rsp_t wb_rsp
);
	import lc3b_pkg::*;

	arb_state_t state;
	arb_state_t state_nxt;
	logic f_gnt;
	logic d_gnt;

	assign f_gnt = state == fetch_grant;
	assign d_gnt = state == data_grant;

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				// data side wins a tie
				if (d_req.stb)
					state_nxt = data_grant;
				else if (f_req.stb)
					state_nxt = fetch_grant;
			end
			default: begin
				if (wb_rsp.ack)
					state_nxt = idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= state_nxt;
	end

	assign wb_req = d_gnt ? d_req : (f_gnt ? f_req : '0);

	assign f_rsp.ack = f_gnt && wb_rsp.ack;
	assign f_rsp.dat = wb_rsp.dat;
	assign d_rsp.ack = d_gnt && wb_rsp.ack;
	assign d_rsp.dat = wb_rsp.dat;

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({f_gnt, d_gnt}));
	// masters keep asking until their ack comes back
	a_held_req: assert property (@(posedge clk) disable iff (!rst_n)
		(f_gnt || d_gnt) && !wb_rsp.ack |-> wb_req.stb);

endmodule

// ==== logic/lc3b_pipe.sv ====
`timescale 1ns/1ns

module lc3b_pipe (
	input  logic clk,
	input  logic rst_n,
	output lc3b_pkg::wb_req_t wb_req,
	input  lc3b_pkg::wb_rsp_t wb_rsp,
	output logic halted
);
	import lc3b_pkg::*;

	wb_req_t f_req;
	wb_rsp_t f_rsp;
	wb_req_t d_req;
	wb_rsp_t d_rsp;

	// fetch side and the fetch/decode register
	logic f_valid;
	lc3b_word f_npc;
	lc3b_word f_ir;
	logic fd_valid;
	lc3b_word fd_npc;
	lc3b_word fd_ir;

	lc3b_reg rd_sr1;
	lc3b_reg rd_sr2;
	lc3b_word sr1_data;
	lc3b_word sr2_data;
	lc3b_nzp cc;

	de_ex_t de_next;
	de_ex_t de_ex;
	ex_mem_t ex_next;
	ex_mem_t ex_mem;
	mem_wb_t mem_next;
	mem_wb_t mem_wb;

	logic dep_stall;
	logic dec_br_hold;
	logic br_hold;
	logic trap_seen;
	logic redirect;
	lc3b_word target;
	logic mem_busy;
	logic fd_hold;
	logic cc_busy;
	logic wb_ld_reg;
	logic wb_ld_cc;
	lc3b_word wb_data;

	assign fd_hold = dep_stall || mem_busy;
	// branch stays unresolved until it leaves execute
	assign br_hold = dec_br_hold || (de_ex.valid && de_ex.ctrl.opcode == op_br);
	assign cc_busy = (de_ex.valid && de_ex.ctrl.ld_cc) || (ex_mem.valid && ex_mem.ctrl.ld_cc) ||
		(mem_wb.valid && mem_wb.ctrl.ld_cc);

	// write-back
	assign wb_ld_reg = mem_wb.valid && mem_wb.ctrl.ld_reg;
	assign wb_ld_cc = mem_wb.valid && mem_wb.ctrl.ld_cc;
	assign wb_data = (mem_wb.ctrl.opcode == op_ldr) ? mem_wb.data : mem_wb.result;

	fetch i_fetch (
		.clk,
		.rst_n,
		.stall(fd_hold),
		.br_hold,
		.redirect,
		.target,
		.halt(trap_seen),
		.req(f_req),
		.rsp(f_rsp),
		.f_valid,
		.f_npc,
		.f_ir
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fd_valid <= 1'b0;
		else if (!fd_hold)
			fd_valid <= f_valid;
	end

	always_ff @(posedge clk) begin
		if (!fd_hold) begin
			fd_npc <= f_npc;
			fd_ir <= f_ir;
		end
	end

	decode i_decode (
		.f_valid(fd_valid),
		.f_ir(fd_ir),
		.f_npc(fd_npc),
		.rd_sr1,
		.rd_sr2,
		.sr1_data,
		.sr2_data,
		.ex_dr(de_ex.dr),
		.ex_ld_reg(de_ex.valid && de_ex.ctrl.ld_reg),
		.mem_dr(ex_mem.dr),
		.mem_ld_reg(ex_mem.valid && ex_mem.ctrl.ld_reg),
		.wb_dr(mem_wb.dr),
		.wb_ld_reg,
		.cc_busy,
		.de_out(de_next),
		.dep_stall,
		.br_hold(dec_br_hold),
		.trap_seen
	);

	lc3b_regfile i_regfile (
		.clk,
		.rst_n,
		.rd_sr1,
		.rd_sr2,
		.sr1_data,
		.sr2_data,
		.ld_reg(wb_ld_reg),
		.ld_cc(wb_ld_cc),
		.wr_dr(mem_wb.dr),
		.wr_data(wb_data),
		.cc
	);

	execute i_execute (
		.de_in(de_ex),
		.cc,
		.ex_out(ex_next),
		.redirect,
		.target
	);

	mem_stage i_mem_stage (
		.clk,
		.rst_n,
		.ex_in(ex_mem),
		.req(d_req),
		.rsp(d_rsp),
		.mem_out(mem_next),
		.mem_busy
	);

	bus_arbiter i_bus_arbiter (
		.clk,
		.rst_n,
		.f_req,
		.f_rsp,
		.d_req,
		.d_rsp,
		.wb_req,
		.wb_rsp
	);

	// later stages all freeze on a pending data access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			de_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else if (!mem_busy) begin
			de_ex <= de_next;
			ex_mem <= ex_next;
			mem_wb <= mem_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (mem_wb.valid && mem_wb.ctrl.opcode == op_trap)
			halted <= 1'b1;
	end

endmodule

// ==== bench/lc3b_pipe_tb.sv ====
`timescale 1ns/1ns
`include "lc3b_config.svh"

module lc3b_pipe_tb;
	import lc3b_pkg::*;

	localparam int num_progs = 12;
	localparam int halt_limit = 128 * 36;
	localparam int watchdog_ns = num_progs * 128 * 40 * 100;

	logic clk;
	logic rst_n = 1'b0;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp = '0;
	logic halted;

	logic [31:0] lfsr;
	logic [15:0] image [256];
	logic [15:0] model_mem [256];
	logic [15:0] mem [256];
	logic [1:0] wait_tab [1024];

	// bus slave bookkeeping
	logic [9:0] wait_idx = '0;
	logic [1:0] wait_left;
	logic seen_first;
	logic [15:0] first_adr;
	// byte enables of every access anded together
	logic [1:0] sel_all;
	int n_fetch;
	int n_data;
	int late_req;
	logic [15:0] st_adr [$];
	logic [15:0] st_dat [$];

	// reference model results
	logic [15:0] exp_adr [$];
	logic [15:0] exp_dat [$];
	int exp_data;
	int exp_fetch;

	int checks = 0;
	int errors = 0;
	int test_errors;

	lc3b_pipe i_lc3b_pipe (
		.clk,
		.rst_n,
		.wb_req,
		.wb_rsp,
		.halted
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#watchdog_ns;
		$display("watchdog expired before all programs finished");
		$display("ERRORS FOUND");
		$finish;
	end

	// wishbone memory, image reloaded while in reset
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= image[i];
			wb_rsp <= '0;
			wait_left <= wait_tab[wait_idx];
			seen_first <= 1'b0;
			first_adr <= 16'hffff;
			sel_all <= 2'b11;
			n_fetch <= 0;
			n_data <= 0;
			late_req <= 0;
			st_adr.delete();
			st_dat.delete();
		end else begin
			wb_rsp.ack <= 1'b0;
			if (halted && (wb_req.cyc || wb_req.stb))
				late_req <= late_req + 1;
			if (wb_req.stb && !seen_first) begin
				seen_first <= 1'b1;
				first_adr <= wb_req.adr;
			end
			if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
				if (wait_left != 2'd0) begin
					wait_left <= wait_left - 2'd1;
				end else begin
					wb_rsp.ack <= 1'b1;
					wait_idx <= wait_idx + 10'd1;
					wait_left <= wait_tab[wait_idx + 10'd1];
					sel_all <= sel_all & wb_req.sel;
					if (wb_req.we) begin
						mem[wb_req.adr[8:1]] <= wb_req.dat;
						st_adr.push_back(wb_req.adr);
						st_dat.push_back(wb_req.dat);
					end else begin
						wb_rsp.dat <= mem[wb_req.adr[8:1]];
					end
					// program lives below byte 0x100, data above
					if (wb_req.adr >= 16'h0100)
						n_data <= n_data + 1;
					else
						n_fetch <= n_fetch + 1;
				end
			end
		end
	end

	function automatic logic [15:0] rand_bits(input int n);
		logic fb;
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	function automatic logic [15:0] random_instr(input int idx, input int len);
		logic [2:0] kind;
		logic [2:0] dr;
		logic [2:0] sa;
		logic [2:0] sb;
		logic [8:0] off;
		logic [15:0] ir;
		int room;
		kind = 3'(rand_bits(3));
		// r6 stays the data pointer
		dr = 3'(rand_bits(3));
		if (dr > 3'd5)
			dr = dr - 3'd2;
		sa = 3'(rand_bits(3));
		sb = 3'(rand_bits(3));
		case (kind)
			3'd0: ir = {4'b0001, dr, sa, 3'b000, sb};
			3'd1: ir = {4'b0001, dr, sa, 1'b1, 5'(rand_bits(5))};
			3'd2: begin
				if (rand_bits(1) != 16'd0)
					ir = {4'b0101, dr, sa, 1'b1, 5'(rand_bits(5))};
				else
					ir = {4'b0101, dr, sa, 3'b000, sb};
			end
			3'd3: ir = {4'b1001, dr, sa, 6'b111111};
			3'd4: begin
				// forward only, never past the closing trap
				room = len - 2 - idx;
				off = 9'(rand_bits(3));
				if (int'(off) > room)
					off = 9'(room);
				ir = {4'b0000, 3'(rand_bits(3)), off};
			end
			3'd5: ir = {4'b1110, dr, 9'(rand_bits(9))};
			3'd6: ir = {4'b0110, dr, 3'd6, 6'(rand_bits(6))};
			default: ir = {4'b0111, sb, 3'd6, 6'(rand_bits(6))};
		endcase
		return ir;
	endfunction

	task automatic build_program(input int len);
		// lea r6 to byte 0x180, middle of the data words
		image[0] = {4'b1110, 3'd6, 9'd191};
		for (int i = 1; i < len - 1; i++)
			image[i] = random_instr(i, len);
		for (int i = len - 1; i < 128; i++)
			image[i] = 16'hf025;
		for (int i = 128; i < 256; i++)
			image[i] = rand_bits(16);
	endtask

	// sequential isa model, one instruction at a time
	task automatic run_model();
		logic [15:0] r [8];
		logic [15:0] ir;
		logic [15:0] pc;
		logic [15:0] val;
		logic [15:0] adr;
		logic [2:0] cc;
		logic wr;
		logic stop;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		cc = 3'b010;
		pc = `LC3B_RESET_PC;
		stop = 1'b0;
		exp_adr.delete();
		exp_dat.delete();
		exp_data = 0;
		exp_fetch = 0;
		while (!stop && exp_fetch < 256) begin
			ir = model_mem[pc[8:1]];
			pc = pc + 16'd2;
			exp_fetch++;
			wr = 1'b0;
			val = '0;
			case (ir[15:12])
				4'b0001: begin
					val = r[ir[8:6]] + (ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]]);
					wr = 1'b1;
				end
				4'b0101: begin
					val = r[ir[8:6]] & (ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]]);
					wr = 1'b1;
				end
				4'b1001: begin
					val = ~r[ir[8:6]];
					wr = 1'b1;
				end
				4'b0000: begin
					if (|(ir[11:9] & cc))
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
				end
				4'b1110: r[ir[11:9]] = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
				4'b0110: begin
					adr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
					val = model_mem[adr[8:1]];
					wr = 1'b1;
					exp_data++;
				end
				4'b0111: begin
					adr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
					model_mem[adr[8:1]] = r[ir[11:9]];
					exp_adr.push_back(adr);
					exp_dat.push_back(r[ir[11:9]]);
					exp_data++;
				end
				default: stop = 1'b1;
			endcase
			if (wr) begin
				r[ir[11:9]] = val;
				cc = val[15] ? 3'b100 : ((val == 16'h0) ? 3'b010 : 3'b001);
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			test_errors++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic run_test(input int t);
		int len;
		int cycles;
		int n;
		test_errors = 0;
		@(posedge clk);
		rst_n <= 1'b0;
		len = 24 + int'(rand_bits(5));
		build_program(len);
		for (int i = 0; i < 256; i++)
			model_mem[i] = image[i];
		run_model();
		repeat (10) @(posedge clk);
		check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
		check_value("wb_req.stb", 32'(wb_req.stb), 32'd0);
		rst_n <= 1'b1;
		cycles = 0;
		while (!halted && cycles < halt_limit) begin
			@(posedge clk);
			cycles++;
		end
		checks++;
		assert (halted) else begin
			errors++;
			test_errors++;
			$display("program %0d: halted did not rise within %0d cycles", t, halt_limit);
		end
		// stay a while to catch any late request
		repeat (20) @(posedge clk);
		check_value("first fetch adr", 32'(first_adr), 32'(`LC3B_RESET_PC));
		check_value("wb_req.sel", 32'(sel_all), 32'd3);
		check_value("store count", st_adr.size(), exp_adr.size());
		n = (st_adr.size() < exp_adr.size()) ? st_adr.size() : exp_adr.size();
		for (int i = 0; i < n; i++) begin
			check_value($sformatf("store %0d adr", i), 32'(st_adr[i]), 32'(exp_adr[i]));
			check_value($sformatf("store %0d dat", i), 32'(st_dat[i]), 32'(exp_dat[i]));
		end
		check_value("data accesses", n_data, exp_data);
		check_value("fetch accesses", n_fetch, exp_fetch);
		check_value("requests after halt", late_req, 0);
		$display("program %0d: %0d instructions, %0d stores, %0d data accesses, %s", t,
			exp_fetch, exp_adr.size(), exp_data, (test_errors == 0) ? "ok" : "failed");
	endtask

	initial begin
		lfsr = 32'hf8ed;
		for (int i = 0; i < 1024; i++)
			wait_tab[i] = 2'(rand_bits(2));
		for (int t = 0; t < num_progs; t++)
			run_test(t);
		$display("%0d tests, %0d checks, %0d errors", num_progs, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== lc3b_pipe.f ====
+incdir+include
logic/lc3b_pkg.sv
logic/lc3b_regfile.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_stage.sv
logic/bus_arbiter.sv
logic/lc3b_pipe.sv
bench/lc3b_pipe_tb.sv

// ==== Makefile ====
TOP = lc3b_pipe_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) \
		-f lc3b_pipe.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then exit 1; fi
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
